// File: bch_chien.sv
`timescale 1ns/10ps

module bch_chien (
	input logic clk,
	input logic arst_n,
	input logic loc_req,
	output logic loc_ack,
	input bch_pkg::gf_elem_t loc_sigma1,
	input bch_pkg::gf_elem_t loc_sigma2,
	input bch_pkg::err_kind_t loc_kind,
	input logic [bch_pkg::code_n-1:0] loc_word,
	output logic out_req,
	input logic out_ack,
	output logic [bch_pkg::code_n-1:0] out_word,
	output logic [1:0] out_err_count,
	output logic out_fail
);

	bch_pkg::chien_state_t state;
	bch_pkg::err_kind_t kind_q;
	bch_pkg::gf_elem_t term1; // sigma1 * alpha^(-pos).
	bch_pkg::gf_elem_t term2; // sigma2 * alpha^(-2 pos).
	logic [bch_pkg::code_n-1:0] recv_q;
	logic [bch_pkg::code_n-1:0] fix_q;
	logic [3:0] pos;
	logic [1:0] root_cnt;
	logic capture;
	logic skip;
	logic root;
	logic raise;
	logic fail;

	assign capture = (state == bch_pkg::chien_idle) && loc_req && !loc_ack;
	assign skip = (loc_kind == bch_pkg::no_error) || (loc_kind == bch_pkg::uncorrectable);
	assign root = (state == bch_pkg::chien_search) && ((4'h1 ^ term1 ^ term2) == 4'h0);
	assign raise = (state == bch_pkg::chien_hand) && !out_req && !out_ack;

	// the search must find exactly as many roots as the locator expects.
	always_comb begin
		case (kind_q)
			bch_pkg::one_error: fail = (root_cnt != 2'd1);
			bch_pkg::two_error: fail = (root_cnt != 2'd2);
			bch_pkg::uncorrectable: fail = 1'b1;
			default: fail = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			kind_q <= loc_kind;
			term1 <= loc_sigma1;
			term2 <= loc_sigma2;
			recv_q <= loc_word;
			fix_q <= loc_word;
		end else if (state == bch_pkg::chien_search) begin
			// step both terms to the next position, alpha^-1 = alpha^14.
			term1 <= bch_pkg::gf_mul(term1, bch_pkg::alpha_pow(4'd14));
			term2 <= bch_pkg::gf_mul(term2, bch_pkg::alpha_pow(4'd13));
			if (root)
				fix_q[pos] <= ~fix_q[pos];
		end
		if (raise) begin
			out_word <= fail ? recv_q : fix_q; // a failed word leaves untouched.
			out_err_count <= fail ? 2'd0 : root_cnt;
			out_fail <= fail;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= bch_pkg::chien_idle;
			loc_ack <= 1'b0;
			out_req <= 1'b0;
			pos <= 4'd0;
			root_cnt <= 2'd0;
		end else begin
			if (capture)
				loc_ack <= 1'b1;
			else if (loc_ack && !loc_req)
				loc_ack <= 1'b0;
			case (state)
				bch_pkg::chien_idle: begin
					if (capture) begin
						pos <= 4'd0;
						root_cnt <= 2'd0;
						state <= skip ? bch_pkg::chien_hand : bch_pkg::chien_search;
					end
				end
				bch_pkg::chien_search: begin
					if (root)
						root_cnt <= root_cnt + 2'd1;
					pos <= pos + 4'd1;
					if (pos == 4'd14)
						state <= bch_pkg::chien_hand;
				end
				default: begin
					if (raise) begin
						out_req <= 1'b1;
					end else if (out_req && out_ack) begin
						out_req <= 1'b0;
						state <= bch_pkg::chien_idle;
					end
				end
			endcase
		end
	end

endmodule

// File: bch_decoder_checker.sv
`timescale 1ns/10ps

module bch_decoder_checker (
	input logic clk,
	input logic arst_n,
	input logic syn_req,
	input logic syn_ack,
	input bch_pkg::gf_elem_t syn_s1,
	input bch_pkg::gf_elem_t syn_s3,
	input logic [bch_pkg::code_n-1:0] syn_word,
	input logic loc_req,
	input logic loc_ack,
	input bch_pkg::gf_elem_t loc_sigma1,
	input bch_pkg::gf_elem_t loc_sigma2,
	input bch_pkg::err_kind_t loc_kind,
	input logic [bch_pkg::code_n-1:0] loc_word,
	input logic out_req,
	input logic out_ack,
	input logic [bch_pkg::code_n-1:0] out_word,
	input logic [1:0] out_err_count,
	input logic out_fail
);

	int violations = 0; // counts every failed assertion below.

	// a request stays up until the receiver answers it.
	syn_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
		syn_req && !syn_ack |=> syn_req)
		else begin
			violations++;
			$error("syn_req fell before syn_ack rose");
		end
	loc_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
		loc_req && !loc_ack |=> loc_req)
		else begin
			violations++;
			$error("loc_req fell before loc_ack rose");
		end
	out_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
		out_req && !out_ack |=> out_req)
		else begin
			violations++;
			$error("out_req fell before out_ack rose");
		end

	// the acknowledge is only withdrawn once the request is gone.
	syn_ack_hold: assert property (@(posedge clk) disable iff (!arst_n)
		syn_ack && syn_req |=> syn_ack)
		else begin
			violations++;
			$error("syn_ack fell while syn_req was high");
		end
	loc_ack_hold: assert property (@(posedge clk) disable iff (!arst_n)
		loc_ack && loc_req |=> loc_ack)
		else begin
			violations++;
			$error("loc_ack fell while loc_req was high");
		end
	out_ack_hold: assert property (@(posedge clk) disable iff (!arst_n)
		out_ack && out_req |=> out_ack)
		else begin
			violations++;
			$error("out_ack fell while out_req was high");
		end

	syn_data_stable: assert property (@(posedge clk) disable iff (!arst_n)
		syn_req && $past(syn_req) |-> $stable({syn_s1, syn_s3, syn_word}))
		else begin
			violations++;
			$error("syndrome data changed while syn_req was high");
		end
	loc_data_stable: assert property (@(posedge clk) disable iff (!arst_n)
		loc_req && $past(loc_req) |-> $stable({loc_sigma1, loc_sigma2, loc_kind, loc_word}))
		else begin
			violations++;
			$error("locator data changed while loc_req was high");
		end
	out_data_stable: assert property (@(posedge clk) disable iff (!arst_n)
		out_req && $past(out_req) |-> $stable({out_word, out_err_count, out_fail}))
		else begin
			violations++;
			$error("output data changed while out_req was high");
		end

	out_req_in_reset: assert property (@(posedge clk) !arst_n |-> !out_req)
		else begin
			violations++;
			$error("out_req was high during reset");
		end

endmodule

// File: bch_decoder_tb.sv
`timescale 1ns/10ps

module bch_decoder_tb;

	localparam logic [8:0] gen_poly = 9'h1d1; // x^8 + x^7 + x^6 + x^4 + 1.
	localparam int slow_words = 20;
	localparam int num_words = 4 + 15 + 20 + 10 + 15 + slow_words;
	// 15 bits plus 40 cycles of slack per word at 40 ns, doubled.
	localparam longint watchdog_ns = longint'(num_words) * (15 + 40) * 40 * 2;

	logic clk = 1'b0;
	logic arst_n;
	logic din;
	logic din_valid;
	logic din_first;
	logic din_ready;
	logic out_req;
	logic out_ack;
	logic [14:0] out_word;
	logic [1:0] out_err_count;
	logic out_fail;
	logic [31:0] lcg_state;
	logic [17:0] exp_q[$]; // {fail, count, word} in the order the words were sent.
	logic [14:0] exp_word;
	logic [1:0] exp_count;
	logic exp_fail;
	logic exp_valid;
	logic saw_stall;

	always #20 clk = ~clk;

	bch_decoder_top dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.din(din),
		.din_valid(din_valid),
		.din_first(din_first),
		.din_ready(din_ready),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_word(out_word),
		.out_err_count(out_err_count),
		.out_fail(out_fail)
	);

	bind bch_decoder_top bch_decoder_checker checker_i (
		.clk(clk),
		.arst_n(arst_n),
		.syn_req(syn_req),
		.syn_ack(syn_ack),
		.syn_s1(syn_s1),
		.syn_s3(syn_s3),
		.syn_word(syn_word),
		.loc_req(loc_req),
		.loc_ack(loc_ack),
		.loc_sigma1(loc_sigma1),
		.loc_sigma2(loc_sigma2),
		.loc_kind(loc_kind),
		.loc_word(loc_word),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_word(out_word),
		.out_err_count(out_err_count),
		.out_fail(out_fail)
	);

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = next_rand();
		return int'(r[30:8]) % n; // low bits of an LCG repeat too quickly.
	endfunction

	// carry-less product, then fold bits 6..4 back with x^4 = x + 1.
	function automatic logic [3:0] field_mul(input logic [3:0] a, input logic [3:0] b);
		logic [6:0] p;
		p = '0;
		for (int i = 0; i < 4; i++) begin
			if (b[i])
				p = p ^ (7'(a) << i);
		end
		for (int k = 6; k >= 4; k--) begin
			if (p[k])
				p = p ^ (7'b0010011 << (k - 4));
		end
		return p[3:0];
	endfunction

	function automatic logic [3:0] field_pow(input int e);
		logic [3:0] v;
		v = 4'h1;
		for (int k = 0; k < e % 15; k++)
			v = field_mul(v, 4'h2);
		return v;
	endfunction

	function automatic logic [3:0] field_inv(input logic [3:0] a);
		logic [3:0] res;
		res = 4'h0;
		for (int b = 1; b < 16; b++) begin
			if (field_mul(a, 4'(b)) == 4'h1)
				res = 4'(b);
		end
		return res;
	endfunction

	// systematic form, message in the top seven coefficients.
	function automatic logic [14:0] encode_bch(input logic [6:0] msg);
		logic [14:0] rem;
		rem = {msg, 8'h00};
		for (int k = 14; k >= 8; k--) begin
			if (rem[k])
				rem = rem ^ (15'(gen_poly) << (k - 8));
		end
		return {msg, rem[7:0]};
	endfunction

	function automatic logic [17:0] predict_decode(input logic [14:0] r);
		logic [3:0] s1;
		logic [3:0] s3;
		logic [3:0] s1_cube;
		logic [3:0] sigma2;
		logic [3:0] a;
		logic [14:0] fixed;
		int expected;
		int roots;
		s1 = 4'h0;
		s3 = 4'h0;
		for (int i = 0; i < 15; i++) begin
			if (r[i]) begin
				s1 = s1 ^ field_pow(i);
				s3 = s3 ^ field_pow(3 * i);
			end
		end
		if (s1 == 4'h0)
			return {s3 != 4'h0, 2'd0, r};
		s1_cube = field_mul(s1, field_mul(s1, s1));
		expected = (s3 == s1_cube) ? 1 : 2;
		sigma2 = (s3 == s1_cube) ? 4'h0 : field_mul(s3 ^ s1_cube, field_inv(s1));
		fixed = r;
		roots = 0;
		for (int i = 0; i < 15; i++) begin
			a = field_pow(15 - i); // alpha^-i.
			if ((4'h1 ^ field_mul(s1, a) ^ field_mul(sigma2, field_mul(a, a))) == 4'h0) begin
				fixed[i] = ~fixed[i];
				roots++;
			end
		end
		if (roots != expected)
			return {1'b1, 2'd0, r};
		return {1'b0, 2'(roots), fixed};
	endfunction

	function automatic logic [14:0] error_pattern(input int k);
		logic [14:0] e;
		e = '0;
		while ($countones(e) < k)
			e[rand_below(15)] = 1'b1;
		return e;
	endfunction

	task automatic send_word(input logic [14:0] w, input int gap_max);
		for (int i = 14; i >= 0; i--) begin
			repeat (rand_below(gap_max + 1)) begin
				din_valid <= 1'b0;
				@(posedge clk);
			end
			din <= w[i]; // highest coefficient goes first.
			din_first <= (i == 14);
			din_valid <= 1'b1;
			@(posedge clk);
			while (!din_ready)
				@(posedge clk);
		end
	endtask

	task automatic run_word(input logic [14:0] err, input int gap_max);
		logic [14:0] cw;
		cw = encode_bch(7'(rand_below(128)));
		// up to two errors the answer is known without a model.
		if ($countones(err) <= 2)
			exp_q.push_back({1'b0, 2'($countones(err)), cw});
		else
			exp_q.push_back(predict_decode(cw ^ err));
		send_word(cw ^ err, gap_max);
	endtask

	task automatic take_word(input int delay_max);
		while (exp_q.size() == 0)
			@(posedge clk);
		{exp_fail, exp_count, exp_word} = exp_q[0];
		exp_valid = 1'b1;
		while (!out_req)
			@(posedge clk);
		repeat (rand_below(delay_max + 1))
			@(posedge clk);
		out_ack <= 1'b1;
		do
			@(posedge clk);
		while (out_req);
		out_ack <= 1'b0;
		exp_valid = 1'b0;
		void'(exp_q.pop_front());
	endtask

	word_valid: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(out_req) |-> exp_valid)
		else begin
			$display("Fail at time %0t: out_req rose with no word outstanding", $time);
			$display("TEST FAILED");
			$fatal(1);
		end
	word_value: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(out_req) |-> out_word == exp_word)
		else begin
			$display("Fail at time %0t: out_word %h, expected %h", $time, out_word, exp_word);
			$display("TEST FAILED");
			$fatal(1);
		end
	count_value: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(out_req) |-> out_err_count == exp_count)
		else begin
			$display("Fail at time %0t: out_err_count %0d, expected %0d", $time,
				out_err_count, exp_count);
			$display("TEST FAILED");
			$fatal(1);
		end
	fail_value: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(out_req) |-> out_fail == exp_fail)
		else begin
			$display("Fail at time %0t: out_fail %b, expected %b", $time, out_fail, exp_fail);
			$display("TEST FAILED");
			$fatal(1);
		end

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			saw_stall <= 1'b0;
		else if (!din_ready)
			saw_stall <= 1'b1; // back-pressure reached the input.
	end

	always @(posedge clk) begin
		if (dut_i.checker_i.violations != 0) begin
			$display("the handshake checker reported a protocol violation");
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	initial begin : watchdog
		#(watchdog_ns);
		$display("the decoder stopped producing words before all %0d were checked", num_words);
		$display("TEST FAILED");
		$fatal(1);
	end

	initial begin
		lcg_state = 32'hf2c6_56ca;
		exp_valid = 1'b0;
		arst_n <= 1'b1;
		din <= 1'b0;
		din_valid <= 1'b0;
		din_first <= 1'b0;
		out_ack <= 1'b0;
		#5 arst_n <= 1'b0;
		repeat (10)
			@(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		fork
			begin
				for (int k = 0; k < 4; k++)
					run_word(15'd0, 0);
				for (int p = 0; p < 15; p++)
					run_word(15'd1 << p, 0);
				repeat (20)
					run_word(error_pattern(2), 0);
				repeat (10)
					run_word(error_pattern(3), 0);
				repeat (15)
					run_word(error_pattern(4 + rand_below(3)), 0);
				// mixed correctable words with input gaps and a slow sink.
				repeat (slow_words)
					run_word(error_pattern(rand_below(3)), 1);
				din_valid <= 1'b0;
			end
			begin
				for (int k = 0; k < num_words; k++)
					take_word((k >= num_words - slow_words) ? 80 : 2);
			end
		join
		if (!saw_stall) begin
			$display("din_ready never fell, so back-pressure was not exercised");
			$display("TEST FAILED");
			$fatal(1);
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

// File: bch_decoder_top.sv
`timescale 1ns/10ps

module bch_decoder_top (
	input logic clk,
	input logic arst_n,
	input logic din,
	input logic din_valid,
	input logic din_first,
	output logic din_ready,
	output logic out_req,
	input logic out_ack,
	output logic [bch_pkg::code_n-1:0] out_word,
	output logic [1:0] out_err_count,
	output logic out_fail
);

	logic syn_req;
	logic syn_ack;
	bch_pkg::gf_elem_t syn_s1;
	bch_pkg::gf_elem_t syn_s3;
	logic [bch_pkg::code_n-1:0] syn_word;
	logic loc_req;
	logic loc_ack;
	bch_pkg::gf_elem_t loc_sigma1;
	bch_pkg::gf_elem_t loc_sigma2;
	bch_pkg::err_kind_t loc_kind;
	logic [bch_pkg::code_n-1:0] loc_word;

	// serial input, one bit per clock.
	bch_syndrome syndrome_i (
		.clk(clk),
		.arst_n(arst_n),
		.din(din),
		.din_valid(din_valid),
		.din_first(din_first),
		.din_ready(din_ready),
		.syn_req(syn_req),
		.syn_ack(syn_ack),
		.syn_s1(syn_s1),
		.syn_s3(syn_s3),
		.syn_word(syn_word)
	);

	bch_locator locator_i (
		.clk(clk),
		.arst_n(arst_n),
		.syn_req(syn_req),
		.syn_ack(syn_ack),
		.syn_s1(syn_s1),
		.syn_s3(syn_s3),
		.syn_word(syn_word),
		.loc_req(loc_req),
		.loc_ack(loc_ack),
		.loc_sigma1(loc_sigma1),
		.loc_sigma2(loc_sigma2),
		.loc_kind(loc_kind),
		.loc_word(loc_word)
	);

	bch_chien chien_i (
		.clk(clk),
		.arst_n(arst_n),
		.loc_req(loc_req),
		.loc_ack(loc_ack),
		.loc_sigma1(loc_sigma1),
		.loc_sigma2(loc_sigma2),
		.loc_kind(loc_kind),
		.loc_word(loc_word),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_word(out_word),
		.out_err_count(out_err_count),
		.out_fail(out_fail)
	);

endmodule

// File: bch_locator.sv
`timescale 1ns/10ps

module bch_locator (
	input logic clk,
	input logic arst_n,
	input logic syn_req,
	output logic syn_ack,
	input bch_pkg::gf_elem_t syn_s1,
	input bch_pkg::gf_elem_t syn_s3,
	input logic [bch_pkg::code_n-1:0] syn_word,
	output logic loc_req,
	input logic loc_ack,
	output bch_pkg::gf_elem_t loc_sigma1,
	output bch_pkg::gf_elem_t loc_sigma2,
	output bch_pkg::err_kind_t loc_kind,
	output logic [bch_pkg::code_n-1:0] loc_word
);

	bch_pkg::loc_state_t state;
	bch_pkg::gf_elem_t s1_q;
	bch_pkg::gf_elem_t s3_q;
	bch_pkg::gf_elem_t cube_q; // S1 cubed.
	bch_pkg::gf_elem_t sigma2_d;
	bch_pkg::err_kind_t kind_d;
	logic capture;

	assign capture = (state == bch_pkg::loc_idle) && syn_req && !syn_ack;

	// Peterson's rule for t = 2. With S1 = 0 a nonzero S3 means three or
	// more errors, since one or two errors always leave S1 nonzero.
	always_comb begin
		sigma2_d = '0;
		if (s1_q == '0) begin
			kind_d = (s3_q == '0) ? bch_pkg::no_error : bch_pkg::uncorrectable;
		end else if (s3_q == cube_q) begin
			kind_d = bch_pkg::one_error;
		end else begin
			kind_d = bch_pkg::two_error;
			sigma2_d = bch_pkg::gf_mul(s3_q ^ cube_q, bch_pkg::gf_inv(s1_q));
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			s1_q <= syn_s1;
			s3_q <= syn_s3;
			loc_word <= syn_word;
		end
		if (state == bch_pkg::loc_cube)
			cube_q <= bch_pkg::gf_cube(s1_q);
		if (state == bch_pkg::loc_solve) begin
			loc_sigma1 <= s1_q;
			loc_sigma2 <= sigma2_d;
			loc_kind <= kind_d;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= bch_pkg::loc_idle;
			syn_ack <= 1'b0;
			loc_req <= 1'b0;
		end else begin
			if (capture)
				syn_ack <= 1'b1;
			else if (syn_ack && !syn_req)
				syn_ack <= 1'b0;
			case (state)
				bch_pkg::loc_idle: begin
					if (capture)
						state <= bch_pkg::loc_cube;
				end
				bch_pkg::loc_cube: state <= bch_pkg::loc_solve;
				bch_pkg::loc_solve: state <= bch_pkg::loc_hand;
				default: begin
					// a late ack from the last word holds the new request back.
					if (!loc_req && !loc_ack) begin
						loc_req <= 1'b1;
					end else if (loc_req && loc_ack) begin
						loc_req <= 1'b0;
						state <= bch_pkg::loc_idle;
					end
				end
			endcase
		end
	end

endmodule

// File: bch_pkg.sv
package bch_pkg;

	localparam int gf_m = 4; // bits per field symbol.
	localparam int code_n = 15; // codeword length in bits.

	// x^4 folds back onto x + 1 when a product overflows the symbol.
	localparam logic [gf_m-1:0] gf_poly_low = 4'b0011;

	typedef logic [gf_m-1:0] gf_elem_t;

	typedef enum logic [1:0] {
		loc_idle,
		loc_cube,
		loc_solve,
		loc_hand
	} loc_state_t;

	typedef enum logic [1:0] {
		chien_idle,
		chien_search,
		chien_hand
	} chien_state_t;

	typedef enum logic [1:0] {
		no_error,
		one_error,
		two_error,
		uncorrectable
	} err_kind_t;

	// shift-and-add multiply, reducing after every shift.
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < gf_m; i++) begin
			if (b[i]) begin
				acc = acc ^ sh;
			end
			sh = {sh[gf_m-2:0], 1'b0} ^ (sh[gf_m-1] ? gf_poly_low : '0);
		end
		return acc;
	endfunction

	// table lookup; zero has no inverse and maps to zero.
	function automatic gf_elem_t gf_inv(input gf_elem_t a);
		gf_elem_t tbl [16];
		tbl = '{4'h0, 4'h1, 4'h9, 4'he, 4'hd, 4'hb, 4'h7, 4'h6,
			4'hf, 4'h2, 4'hc, 4'h5, 4'ha, 4'h4, 4'h3, 4'h8};
		return tbl[a];
	endfunction

	function automatic gf_elem_t gf_cube(input gf_elem_t a);
		return gf_mul(a, gf_mul(a, a));
	endfunction

	// powers of the primitive element, exponent taken modulo 15.
	function automatic gf_elem_t alpha_pow(input logic [3:0] i);
		case (i)
			4'd1: return 4'h2;
			4'd2: return 4'h4;
			4'd3: return 4'h8;
			4'd4: return 4'h3;
			4'd5: return 4'h6;
			4'd6: return 4'hc;
			4'd7: return 4'hb;
			4'd8: return 4'h5;
			4'd9: return 4'ha;
			4'd10: return 4'h7;
			4'd11: return 4'he;
			4'd12: return 4'hf;
			4'd13: return 4'hd;
			4'd14: return 4'h9;
			default: return 4'h1; // alpha^0 and alpha^15.
		endcase
	endfunction

endpackage

// File: bch_syndrome.sv
`timescale 1ns/10ps

module bch_syndrome (
	input logic clk,
	input logic arst_n,
	input logic din,
	input logic din_valid,
	input logic din_first,
	output logic din_ready,
	output logic syn_req,
	input logic syn_ack,
	output bch_pkg::gf_elem_t syn_s1,
	output bch_pkg::gf_elem_t syn_s3,
	output logic [bch_pkg::code_n-1:0] syn_word
);

	bch_pkg::gf_elem_t acc_s1;
	bch_pkg::gf_elem_t acc_s3;
	logic [bch_pkg::code_n-1:0] acc_word;
	logic [3:0] bit_cnt; // bits taken so far in the current word.
	logic acc_full; // a finished word waits for the hold register.
	logic take;
	logic start;
	logic last_bit;
	logic hold_free;
	logic move;

	// the hold is free once the previous handshake has fully returned to zero.
	assign hold_free = !syn_req && !syn_ack;
	assign move = acc_full && hold_free;
	assign din_ready = !(acc_full && !hold_free);
	assign take = din_valid && din_ready;
	assign start = din_first || (bit_cnt == 4'd0);
	assign last_bit = !start && (bit_cnt == 4'd14);

	// Horner steps, the first bit taken is the coefficient of x^14.
	always_ff @(posedge clk) begin
		if (take) begin
			if (start) begin
				acc_s1 <= {{(bch_pkg::gf_m-1){1'b0}}, din};
				acc_s3 <= {{(bch_pkg::gf_m-1){1'b0}}, din};
				acc_word <= {{(bch_pkg::code_n-1){1'b0}}, din};
			end else begin
				acc_s1 <= bch_pkg::gf_mul(acc_s1, bch_pkg::alpha_pow(4'd1)) ^
					{{(bch_pkg::gf_m-1){1'b0}}, din};
				acc_s3 <= bch_pkg::gf_mul(acc_s3, bch_pkg::alpha_pow(4'd3)) ^
					{{(bch_pkg::gf_m-1){1'b0}}, din};
				acc_word <= {acc_word[bch_pkg::code_n-2:0], din};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (move) begin
			syn_s1 <= acc_s1;
			syn_s3 <= acc_s3;
			syn_word <= acc_word;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt <= 4'd0;
			acc_full <= 1'b0;
			syn_req <= 1'b0;
		end else begin
			if (take) begin
				if (last_bit)
					bit_cnt <= 4'd0; // next bit opens a new word.
				else if (start)
					bit_cnt <= 4'd1;
				else
					bit_cnt <= bit_cnt + 4'd1;
			end
			if (take && last_bit)
				acc_full <= 1'b1;
			else if (move)
				acc_full <= 1'b0;
			if (move)
				syn_req <= 1'b1;
			else if (syn_req && syn_ack)
				syn_req <= 1'b0;
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# Build the BCH decoder testbench with Verilator, run it and look for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module bch_decoder_tb -o bch_decoder_sim -f sources.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

sim_out=$(./obj_dir/bch_decoder_sim)
status=$?
printf '%s\n' "$sim_out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TEST PASSED"; then
	exit 0
fi
echo "pass line not found in the simulation output"
exit 1

// File: sources.f
bch_pkg.sv
bch_syndrome.sv
bch_locator.sv
bch_chien.sv
bch_decoder_top.sv
bch_decoder_checker.sv
bch_decoder_tb.sv
